//--- logic/rpc_phy_pkg.sv
package rpc_phy_pkg;

  ////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////

  // One internal SDR slot per clk_0_i cycle
  localparam int BUS_W = 32;
  // DRAM DB pins, half a slot per clock edge
  localparam int DB_W = 16;
  // Default DMA word, eight slots
  localparam int WORD_W_DEF = 256;
  // Burst write mask, sent as two slots
  localparam int MASK_W = 64;

  ////////////////////////////////////////
  // Command encoding
  ////////////////////////////////////////

  // Opcodes in the top two command bits
  localparam logic [1:0] OP_WRITE = 2'b01;
  localparam logic [1:0] OP_READ  = 2'b10;

  // Command fields as they sit on the bus
  typedef struct packed {
    logic [1:0]  op;
    // Burst length in words minus one
    logic [3:0]  words_m1;
    // Passed to the DRAM as is
    logic [25:0] addr;
  } rpc_cmd_t;

  // One bus slot, seen as raw bits or as a command
  typedef union packed {
    logic [BUS_W-1:0] raw;
    rpc_cmd_t         cmd;
  } rpc_slot_u;

  // What the write path puts on db_o
  typedef enum logic [1:0] {
    TYPE_CMD  = 2'b00,
    TYPE_DATA = 2'b01,
    TYPE_MASK = 2'b10
  } rpc_type_e;

endpackage

//--- logic/rpc_phy_ctrl.sv
`timescale 1ns/100ps

module rpc_phy_ctrl #(
  parameter int WORD_W = rpc_phy_pkg::WORD_W_DEF
) (
  input  logic                   clk_0_i,
  input  logic                   rst_ni,
  input  rpc_phy_pkg::rpc_slot_u cmd_i,
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  logic                   word_done_i,
  output logic                   cmd_load_o,
  output logic                   data_ready_o,
  output logic                   mask_sel_o,
  output rpc_phy_pkg::rpc_type_e type_sel_o,
  output logic [2:0]             slot_sel_o,
  output logic                   rd_active_o,
  output logic                   rd_last_word_o,
  output logic                   cs_no,
  output logic                   stb_o,
  output logic                   db_oe_o
);

  // Slots per word, at most eight with a 3-bit select
  localparam int SLOTS = WORD_W / rpc_phy_pkg::BUS_W;
  localparam logic [2:0] SLOT_LAST = 3'(SLOTS - 1);

  // FSM encoding
  localparam logic [2:0] ST_IDLE    = 3'd0;
  localparam logic [2:0] ST_CMD     = 3'd1;
  localparam logic [2:0] ST_MASK    = 3'd2;
  localparam logic [2:0] ST_WR_DATA = 3'd3;
  localparam logic [2:0] ST_RD_WAIT = 3'd4;

  logic [2:0] state_q, state_d;
  logic [1:0] op_q, op_d;
  // Words still to go after the current one
  logic [3:0] cnt_q, cnt_d;
  logic [2:0] slot_q, slot_d;
  logic       mask_q, mask_d;
  // Final read word seen, valid goes out this cycle
  logic       rd_fin_q, rd_fin_d;
  logic       accept;
  logic       slot_wrap;

  assign cmd_ready_o = (state_q == ST_IDLE);
  assign accept      = cmd_valid_i & cmd_ready_o;
  assign cmd_load_o  = accept;
  assign slot_wrap   = (slot_q == SLOT_LAST);

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    state_d  = state_q;
    op_d     = op_q;
    cnt_d    = cnt_q;
    slot_d   = slot_q;
    mask_d   = mask_q;
    rd_fin_d = rd_fin_q;
    case (state_q)
      ST_IDLE: begin
        // Latch opcode and length from the command view
        if (accept) begin
          op_d     = cmd_i.cmd.op;
          cnt_d    = cmd_i.cmd.words_m1;
          slot_d   = '0;
          mask_d   = 1'b0;
          rd_fin_d = 1'b0;
          state_d  = ST_CMD;
        end
      end
      ST_CMD: begin
        if (op_q == rpc_phy_pkg::OP_WRITE) begin
          state_d = ST_MASK;
        end else if (op_q == rpc_phy_pkg::OP_READ) begin
          state_d = ST_RD_WAIT;
        end else begin
          // Other opcodes carry no data phase
          state_d = ST_IDLE;
        end
      end
      ST_MASK: begin
        // Two mask slots, low half of the mask first
        mask_d = ~mask_q;
        if (mask_q) begin
          state_d = ST_WR_DATA;
        end
      end
      ST_WR_DATA: begin
        slot_d = slot_wrap ? 3'd0 : slot_q + 3'd1;
        if (slot_wrap) begin
          if (cnt_q == 4'd0) begin
            state_d = ST_IDLE;
          end else begin
            cnt_d = cnt_q - 4'd1;
          end
        end
      end
      ST_RD_WAIT: begin
        // Hold one extra cycle so ready follows the last valid
        if (rd_fin_q) begin
          state_d = ST_IDLE;
        end else if (word_done_i) begin
          if (cnt_q == 4'd0) begin
            rd_fin_d = 1'b1;
          end else begin
            cnt_d = cnt_q - 4'd1;
          end
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_0_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ST_IDLE;
      op_q     <= 2'b00;
      cnt_q    <= 4'd0;
      slot_q   <= 3'd0;
      mask_q   <= 1'b0;
      rd_fin_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      op_q     <= op_d;
      cnt_q    <= cnt_d;
      slot_q   <= slot_d;
      mask_q   <= mask_d;
      rd_fin_q <= rd_fin_d;
    end
  end

  ////////////////////////////////////////
  // Pin and datapath control
  ////////////////////////////////////////

  // Chip select spans the whole burst
  assign cs_no   = (state_q == ST_IDLE);
  assign stb_o   = (state_q == ST_CMD);
  assign db_oe_o = (state_q == ST_CMD) || (state_q == ST_MASK) || (state_q == ST_WR_DATA);

  // Next word requested one cycle ahead of its first slot
  assign data_ready_o = ((state_q == ST_MASK) && !mask_q) ||
                        ((state_q == ST_WR_DATA) && slot_wrap && (cnt_q != 4'd0));

  always_comb begin
    case (state_q)
      ST_MASK:    type_sel_o = rpc_phy_pkg::TYPE_MASK;
      ST_WR_DATA: type_sel_o = rpc_phy_pkg::TYPE_DATA;
      default:    type_sel_o = rpc_phy_pkg::TYPE_CMD;
    endcase
  end

  assign slot_sel_o     = slot_q;
  assign mask_sel_o     = mask_q;
  assign rd_active_o    = (state_q == ST_RD_WAIT) && !rd_fin_q;
  assign rd_last_word_o = (state_q == ST_RD_WAIT) && (cnt_q == 4'd0);

endmodule

//--- logic/rpc_wr_path.sv
`timescale 1ns/100ps

module rpc_wr_path #(
  parameter int WORD_W = rpc_phy_pkg::WORD_W_DEF
) (
  input  logic                           clk_0_i,
  input  logic                           rst_ni,
  input  rpc_phy_pkg::rpc_slot_u         cmd_i,
  input  logic [rpc_phy_pkg::MASK_W-1:0] mask_i,
  input  logic [WORD_W-1:0]              data_i,
  input  logic                           cmd_load_i,
  input  logic                           word_load_i,
  input  rpc_phy_pkg::rpc_type_e         type_sel_i,
  input  logic [2:0]                     slot_sel_i,
  input  logic                           mask_sel_i,
  output logic [rpc_phy_pkg::BUS_W-1:0]  db_o
);

  localparam int BW = rpc_phy_pkg::BUS_W;
  localparam int HW = rpc_phy_pkg::DB_W;

  rpc_phy_pkg::rpc_slot_u         cmd_q;
  logic [rpc_phy_pkg::MASK_W-1:0] mask_q;
  logic [WORD_W-1:0]              word_q;
  logic [BW-1:0]                  mask_slot;
  logic [BW-1:0]                  data_slot;

  ////////////////////////////////////////
  // Holding registers
  ////////////////////////////////////////

  // Command shown on the bus in the cycle after acceptance
  always_ff @(posedge clk_0_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_q <= '0;
    end else if (cmd_load_i) begin
      cmd_q <= cmd_i;
    end
  end

  // Mask sampled together with the command
  always_ff @(posedge clk_0_i) begin
    if (cmd_load_i) begin
      mask_q <= mask_i;
    end
  end

  // Pipeline stage between the DMA side and the slot mux
  always_ff @(posedge clk_0_i) begin
    if (word_load_i) begin
      word_q <= data_i;
    end
  end

  ////////////////////////////////////////
  // Slot forming
  ////////////////////////////////////////

  always_comb begin
    // Lower-numbered bits go out on the rising edge half
    if (mask_sel_i) begin
      mask_slot = {mask_q[32 +: HW], mask_q[48 +: HW]};
    end else begin
      mask_slot = {mask_q[0 +: HW], mask_q[16 +: HW]};
    end
    data_slot = {word_q[int'(slot_sel_i) * BW +: HW],
                 word_q[int'(slot_sel_i) * BW + HW +: HW]};
  end

  // Bus type multiplexer
  always_comb begin
    case (type_sel_i)
      rpc_phy_pkg::TYPE_MASK: db_o = mask_slot;
      rpc_phy_pkg::TYPE_DATA: db_o = data_slot;
      default:                db_o = cmd_q.raw;
    endcase
  end

endmodule

//--- logic/rpc_rd_path.sv
`timescale 1ns/100ps

module rpc_rd_path #(
  parameter int WORD_W = rpc_phy_pkg::WORD_W_DEF
) (
  input  logic                          clk_0_i,
  input  logic                          rst_ni,
  input  logic [rpc_phy_pkg::BUS_W-1:0] db_i,
  input  logic                          rd_valid_i,
  input  logic                          rd_active_i,
  input  logic                          rd_last_word_i,
  output logic                          word_done_o,
  output logic [WORD_W-1:0]             data_o,
  output logic                          data_valid_o,
  output logic                          data_last_o
);

  localparam int BW = rpc_phy_pkg::BUS_W;
  localparam int SLOTS = WORD_W / BW;
  localparam logic [2:0] SLOT_LAST = 3'(SLOTS - 1);

  logic [2:0]        slot_q;
  logic [WORD_W-1:0] asm_q, asm_d;
  logic [WORD_W-1:0] data_q;
  logic              valid_q;
  logic              last_q;
  logic              take;

  // Slots outside the read phase are dropped
  assign take        = rd_valid_i & rd_active_i;
  assign word_done_o = take && (slot_q == SLOT_LAST);

  ////////////////////////////////////////
  // Slot de-multiplexer
  ////////////////////////////////////////

  // First slot of a word lands in the lowest bits
  always_comb begin
    asm_d = asm_q;
    if (take) begin
      asm_d[int'(slot_q) * BW +: BW] = db_i;
    end
  end

  always_ff @(posedge clk_0_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_q <= 3'd0;
    end else if (take) begin
      slot_q <= (slot_q == SLOT_LAST) ? 3'd0 : slot_q + 3'd1;
    end
  end

  always_ff @(posedge clk_0_i) begin
    asm_q <= asm_d;
  end

  ////////////////////////////////////////
  // DMA output register
  ////////////////////////////////////////

  // Holds the finished word while the next one assembles
  always_ff @(posedge clk_0_i) begin
    if (word_done_o) begin
      data_q <= asm_d;
    end
  end

  always_ff @(posedge clk_0_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= word_done_o;
      last_q  <= word_done_o & rd_last_word_i;
    end
  end

  assign data_o       = data_q;
  assign data_valid_o = valid_q;
  assign data_last_o  = last_q;

endmodule

//--- logic/rpc_phy_top.sv
`timescale 1ns/100ps

module rpc_phy_top #(
  parameter int WORD_W = rpc_phy_pkg::WORD_W_DEF
) (
  input  logic                          clk_0_i,
  input  logic                          rst_ni,
  // Command handshake
  input  rpc_phy_pkg::rpc_slot_u        cmd_i,
  input  logic                          cmd_valid_i,
  output logic                          cmd_ready_o,
  // Write data, pulled one word per data_ready_o
  input  logic [WORD_W-1:0]             data_i,
  input  logic [rpc_phy_pkg::MASK_W-1:0] mask_i,
  output logic                          data_ready_o,
  // Read slots returned by the DRAM
  input  logic [rpc_phy_pkg::BUS_W-1:0] db_i,
  input  logic                          rd_valid_i,
  // Read words toward the DMA
  output logic [WORD_W-1:0]             data_o,
  output logic                          data_valid_o,
  output logic                          data_last_o,
  // DRAM pins
  output logic                          cs_no,
  output logic                          stb_o,
  output logic                          db_oe_o,
  output logic [rpc_phy_pkg::BUS_W-1:0] db_o
);

  // Controller to write path
  logic                   cmd_load;
  logic                   mask_sel;
  logic [2:0]             slot_sel;
  rpc_phy_pkg::rpc_type_e type_sel;

  // Controller and read path
  logic word_done;
  logic rd_active;
  logic rd_last_word;

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  rpc_phy_ctrl #(
    .WORD_W (WORD_W)
  ) u_ctrl (
    .clk_0_i        (clk_0_i),
    .rst_ni         (rst_ni),
    .cmd_i          (cmd_i),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_ready_o    (cmd_ready_o),
    .word_done_i    (word_done),
    .cmd_load_o     (cmd_load),
    .data_ready_o   (data_ready_o),
    .mask_sel_o     (mask_sel),
    .type_sel_o     (type_sel),
    .slot_sel_o     (slot_sel),
    .rd_active_o    (rd_active),
    .rd_last_word_o (rd_last_word),
    .cs_no          (cs_no),
    .stb_o          (stb_o),
    .db_oe_o        (db_oe_o)
  );

  // Word register loads on the same pulse the source sees as ready
  rpc_wr_path #(
    .WORD_W (WORD_W)
  ) u_wr_path (
    .clk_0_i     (clk_0_i),
    .rst_ni      (rst_ni),
    .cmd_i       (cmd_i),
    .mask_i      (mask_i),
    .data_i      (data_i),
    .cmd_load_i  (cmd_load),
    .word_load_i (data_ready_o),
    .type_sel_i  (type_sel),
    .slot_sel_i  (slot_sel),
    .mask_sel_i  (mask_sel),
    .db_o        (db_o)
  );

  rpc_rd_path #(
    .WORD_W (WORD_W)
  ) u_rd_path (
    .clk_0_i        (clk_0_i),
    .rst_ni         (rst_ni),
    .db_i           (db_i),
    .rd_valid_i     (rd_valid_i),
    .rd_active_i    (rd_active),
    .rd_last_word_i (rd_last_word),
    .word_done_o    (word_done),
    .data_o         (data_o),
    .data_valid_o   (data_valid_o),
    .data_last_o    (data_last_o)
  );

endmodule

//--- verif/rpc_phy_checks.svh
`ifndef RPC_PHY_CHECKS_SVH
`define RPC_PHY_CHECKS_SVH

////////////////////////////////////////
// Reference model queues
////////////////////////////////////////

// Expected db_o slots in bus order, with the strobe expected on each
rpc_phy_pkg::rpc_slot_u exp_slot_q[$];
logic                   exp_stb_q[$];
// Expected read words toward the DMA and their last flags
logic [WORD_W-1:0]      exp_word_q[$];
logic                   exp_last_q[$];

// Error counters, one per kind of check
int slot_errs;
int word_errs;
int flag_errs;
int misc_errs;

// Command slot, the only one with the strobe
function automatic void push_cmd_slot(rpc_phy_pkg::rpc_slot_u c);
  exp_slot_q.push_back(c);
  exp_stb_q.push_back(1'b1);
endfunction

// Two mask slots, lower mask bits on the rising edge half
function automatic void push_mask(logic [rpc_phy_pkg::MASK_W-1:0] m);
  rpc_phy_pkg::rpc_slot_u s;
  s.raw = {m[15:0], m[31:16]};
  exp_slot_q.push_back(s);
  exp_stb_q.push_back(1'b0);
  s.raw = {m[47:32], m[63:48]};
  exp_slot_q.push_back(s);
  exp_stb_q.push_back(1'b0);
endfunction

// Eight data slots, slot 0 first
function automatic void push_data_word(logic [WORD_W-1:0] w);
  rpc_phy_pkg::rpc_slot_u s;
  for (int k = 0; k < SLOTS; k++) begin
    s.raw = {w[k * rpc_phy_pkg::BUS_W +: rpc_phy_pkg::DB_W],
             w[k * rpc_phy_pkg::BUS_W + rpc_phy_pkg::DB_W +: rpc_phy_pkg::DB_W]};
    exp_slot_q.push_back(s);
    exp_stb_q.push_back(1'b0);
  end
endfunction

function automatic void push_read_word(logic [WORD_W-1:0] w, logic last);
  exp_word_q.push_back(w);
  exp_last_q.push_back(last);
endfunction

////////////////////////////////////////
// Compare tasks
////////////////////////////////////////

task automatic check_slot(string name, rpc_phy_pkg::rpc_slot_u exp,
                          rpc_phy_pkg::rpc_slot_u act);
  if (act.raw !== exp.raw) begin
    slot_errs++;
    $display("error %s: expected %h got %h at %0t", name, exp.raw, act.raw, $time);
  end
endtask

task automatic check_word(string name, logic [WORD_W-1:0] exp, logic [WORD_W-1:0] act);
  if (act !== exp) begin
    word_errs++;
    $display("error %s: expected %h got %h at %0t", name, exp, act, $time);
  end
endtask

task automatic check_flag(string name, logic exp, logic act);
  if (act !== exp) begin
    flag_errs++;
    $display("error %s: expected %h got %h at %0t", name, exp, act, $time);
  end
endtask

`endif

//--- verif/tb_rpc_phy.sv
`timescale 1ns/100ps

module tb_rpc_phy;

  localparam int WORD_W     = rpc_phy_pkg::WORD_W_DEF;
  localparam int SLOTS      = WORD_W / rpc_phy_pkg::BUS_W;
  localparam int N_CMDS     = 40;
  // Longest write plus worst read latency and gaps, per command
  localparam int MAX_CYCLES = N_CMDS * (3 + 8 * 16 + 9 * 8 + 20);

  logic                                clk_0_i;
  logic                                rst_ni;
  rpc_phy_pkg::rpc_slot_u              cmd_i;
  logic                                cmd_valid_i;
  logic                                cmd_ready_o;
  logic [WORD_W-1:0]                   data_i;
  logic [rpc_phy_pkg::MASK_W-1:0]      mask_i;
  logic                                data_ready_o;
  logic [rpc_phy_pkg::BUS_W-1:0]       db_i;
  logic                                rd_valid_i;
  logic [WORD_W-1:0]                   data_o;
  logic                                data_valid_o;
  logic                                data_last_o;
  logic                                cs_no;
  logic                                stb_o;
  logic                                db_oe_o;
  logic [rpc_phy_pkg::BUS_W-1:0]       db_o;

  int seed = 32'hda9f2fd2;

  // Stimulus lists, filled before reset is released
  rpc_phy_pkg::rpc_slot_u         cmd_list[$];
  logic [rpc_phy_pkg::MASK_W-1:0] mask_list[$];
  logic [WORD_W-1:0]              wr_word_q[$];
  logic [rpc_phy_pkg::BUS_W-1:0]  rd_slot_q[$];
  int                             rd_len_q[$];
  logic [1:0]                     resp_op_q[$];

  int accepts;
  int ready_pulses;
  int exp_ready_pulses;

  `include "rpc_phy_checks.svh"

  rpc_phy_top #(
    .WORD_W (WORD_W)
  ) u_rpc_phy_top (
    .clk_0_i      (clk_0_i),
    .rst_ni       (rst_ni),
    .cmd_i        (cmd_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_ready_o  (cmd_ready_o),
    .data_i       (data_i),
    .mask_i       (mask_i),
    .data_ready_o (data_ready_o),
    .db_i         (db_i),
    .rd_valid_i   (rd_valid_i),
    .data_o       (data_o),
    .data_valid_o (data_valid_o),
    .data_last_o  (data_last_o),
    .cs_no        (cs_no),
    .stb_o        (stb_o),
    .db_oe_o      (db_oe_o),
    .db_o         (db_o)
  );

  initial begin : clock_gen
    clk_0_i = 1'b0;
    forever begin
      #10 clk_0_i = ~clk_0_i;
    end
  end

  function automatic logic [WORD_W-1:0] rand_word();
    logic [WORD_W-1:0] w;
    for (int k = 0; k < SLOTS; k++) begin
      w[k * rpc_phy_pkg::BUS_W +: rpc_phy_pkg::BUS_W] = $random(seed);
    end
    return w;
  endfunction

  ////////////////////////////////////////
  // Command generation and model build
  ////////////////////////////////////////

  task automatic build_commands();
    rpc_phy_pkg::rpc_slot_u         c;
    logic [rpc_phy_pkg::MASK_W-1:0] m;
    logic [WORD_W-1:0]              w;
    logic [31:0]                    r;
    int                             n;
    for (int i = 0; i < N_CMDS; i++) begin
      r = $random(seed);
      c.cmd.op       = r[0] ? rpc_phy_pkg::OP_READ : rpc_phy_pkg::OP_WRITE;
      c.cmd.words_m1 = r[7:4];
      r = $random(seed);
      c.cmd.addr     = r[25:0];
      m = {$random(seed), $random(seed)};
      n = int'(c.cmd.words_m1) + 1;
      cmd_list.push_back(c);
      mask_list.push_back(m);
      resp_op_q.push_back(c.cmd.op);
      push_cmd_slot(c);
      if (c.cmd.op == rpc_phy_pkg::OP_WRITE) begin
        push_mask(m);
        exp_ready_pulses += n;
        for (int j = 0; j < n; j++) begin
          w = rand_word();
          wr_word_q.push_back(w);
          push_data_word(w);
        end
      end else begin
        rd_len_q.push_back(n);
        for (int j = 0; j < n; j++) begin
          w = rand_word();
          for (int k = 0; k < SLOTS; k++) begin
            rd_slot_q.push_back(w[k * rpc_phy_pkg::BUS_W +: rpc_phy_pkg::BUS_W]);
          end
          push_read_word(w, j == n - 1);
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // Write word source and DRAM responder
  ////////////////////////////////////////

  // Next word stays on data_i until a data_ready_o edge takes it
  initial begin : write_feeder
    @(posedge rst_ni);
    data_i = (wr_word_q.size() > 0) ? wr_word_q[0] : '0;
    forever begin
      @(negedge clk_0_i);
      if (data_ready_o) begin
        ready_pulses++;
        @(posedge clk_0_i);
        #2;
        if (wr_word_q.size() > 0) begin
          wr_word_q.delete(0);
        end
        data_i = (wr_word_q.size() > 0) ? wr_word_q[0] : '0;
      end
    end
  end

  // Plays the DRAM, starts after each read command slot
  initial begin : dram_responder
    int          n;
    int          delay;
    logic [31:0] r;
    forever begin
      @(negedge clk_0_i);
      if (stb_o && resp_op_q.size() > 0) begin
        if (resp_op_q.pop_front() == rpc_phy_pkg::OP_READ) begin
          n = rd_len_q.pop_front() * SLOTS;
          r = $random(seed);
          delay = 2 + int'(r[2:0]);
          repeat (delay) @(posedge clk_0_i);
          #2;
          for (int j = 0; j < n; j++) begin
            rd_valid_i = 1'b1;
            db_i       = rd_slot_q.pop_front();
            @(posedge clk_0_i);
            #2;
            rd_valid_i = 1'b0;
            // Random one-cycle gap between slots
            r = $random(seed);
            if (r[0]) begin
              @(posedge clk_0_i);
              #2;
            end
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////

  // Samples at the falling edge where all outputs are settled
  initial begin : bus_monitor
    // Write burst cycles still to come
    int   wr_busy;
    // Read burst open until its final word is shown
    logic rd_busy;
    logic last_exp;
    wr_busy = 0;
    rd_busy = 1'b0;
    @(posedge rst_ni);
    forever begin
      @(negedge clk_0_i);
      // Burst window follows from the commands taken so far
      if (wr_busy > 0 || rd_busy) begin
        check_flag("cmd_ready_o", 1'b0, cmd_ready_o);
        check_flag("cs_no", 1'b0, cs_no);
        if (wr_busy > 0) begin
          wr_busy--;
        end
      end else begin
        // Idle between bursts
        check_flag("cmd_ready_o", 1'b1, cmd_ready_o);
        check_flag("cs_no", 1'b1, cs_no);
        check_flag("db_oe_o", 1'b0, db_oe_o);
        if (cmd_valid_i && cmd_ready_o) begin
          accepts++;
          if (cmd_i.cmd.op == rpc_phy_pkg::OP_WRITE) begin
            wr_busy = 3 + 8 * (int'(cmd_i.cmd.words_m1) + 1);
          end else begin
            rd_busy = 1'b1;
          end
        end
      end
      if (db_oe_o) begin
        if (exp_slot_q.size() == 0) begin
          misc_errs++;
          $display("Bus driven with no slot left to expect at %0t", $time);
        end else begin
          check_slot("db_o", exp_slot_q.pop_front(), db_o);
          check_flag("stb_o", exp_stb_q.pop_front(), stb_o);
        end
      end else begin
        check_flag("stb_o", 1'b0, stb_o);
      end
      if (data_valid_o) begin
        if (exp_word_q.size() == 0) begin
          misc_errs++;
          $display("Read word shown with no word left to expect at %0t", $time);
        end else begin
          check_word("data_o", exp_word_q.pop_front(), data_o);
          last_exp = exp_last_q.pop_front();
          check_flag("data_last_o", last_exp, data_last_o);
          // Ready comes back in the cycle after the final word
          if (last_exp) begin
            rd_busy = 1'b0;
          end
        end
      end else begin
        check_flag("data_last_o", 1'b0, data_last_o);
      end
    end
  end

  initial begin : watchdog
    repeat (MAX_CYCLES) @(posedge clk_0_i);
    $display("Watchdog expired after %0d cycles before the run completed", MAX_CYCLES);
    $display("Test failures found");
    $finish;
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin : main_sequence
    int total;
    rst_ni      = 1'b0;
    cmd_i       = '0;
    cmd_valid_i = 1'b0;
    data_i      = '0;
    mask_i      = '0;
    db_i        = '0;
    rd_valid_i  = 1'b0;
    build_commands();
    repeat (16) @(posedge clk_0_i);
    #2;
    rst_ni = 1'b1;

    // State straight after reset
    @(negedge clk_0_i);
    check_flag("cs_no", 1'b1, cs_no);
    check_flag("stb_o", 1'b0, stb_o);
    check_flag("db_oe_o", 1'b0, db_oe_o);
    check_flag("data_ready_o", 1'b0, data_ready_o);
    check_flag("data_valid_o", 1'b0, data_valid_o);
    check_flag("cmd_ready_o", 1'b1, cmd_ready_o);
    @(posedge clk_0_i);
    #2;

    // Valid stays high from one command to the next
    for (int i = 0; i < N_CMDS; i++) begin
      cmd_i       = cmd_list[i];
      mask_i      = mask_list[i];
      cmd_valid_i = 1'b1;
      do begin
        @(negedge clk_0_i);
      end while (!cmd_ready_o);
      @(posedge clk_0_i);
      #2;
    end
    cmd_valid_i = 1'b0;

    do begin
      @(negedge clk_0_i);
    end while (!(cmd_ready_o && exp_slot_q.size() == 0 && exp_word_q.size() == 0));
    repeat (4) @(negedge clk_0_i);

    if (accepts != N_CMDS) begin
      misc_errs++;
      $display("Accepted %0d commands instead of %0d", accepts, N_CMDS);
    end
    if (ready_pulses != exp_ready_pulses) begin
      misc_errs++;
      $display("Saw %0d write data requests instead of %0d", ready_pulses, exp_ready_pulses);
    end
    if (rd_slot_q.size() != 0) begin
      misc_errs++;
      $display("Expected traffic was left over at the end of the run");
    end

    total = slot_errs + word_errs + flag_errs + misc_errs;
    $display("Errors: slot %0d, word %0d, flag %0d, other %0d",
             slot_errs, word_errs, flag_errs, misc_errs);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+verif
logic/rpc_phy_pkg.sv
logic/rpc_phy_ctrl.sv
logic/rpc_wr_path.sv
logic/rpc_rd_path.sv
logic/rpc_phy_top.sv
verif/tb_rpc_phy.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the RPC PHY testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_rpc_phy -o sim_rpc_phy
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_rpc_phy)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
  exit 0
fi
exit 1
